//--- hdl/axi_burst_pkg.sv
package axi_burst_pkg;

  // AXI burst type, encoded as on the AxBURST wires
  // the allow mask uses the same encoding as its bit index
  typedef enum logic [1:0] {
    e_fixed    = 2'b00,
    e_incr     = 2'b01,
    e_wrap     = 2'b10,
    e_reserved = 2'b11
  } burst_e;

  // why a request was dropped by the admission checker
  // listed in the order the checker tests them
  typedef enum logic [2:0] {
    e_ok           = 3'd0,
    e_bad_type     = 3'd1,
    e_not_allowed  = 3'd2,
    e_bad_size     = 3'd3,
    e_bad_wrap_len = 3'd4,
    e_cross_4k     = 3'd5
  } reject_e;

  // INCR bursts must stay inside one page of this many bytes
  localparam int page_bytes_c = 4096;

  // largest AxLEN, so at most 256 transfers per burst
  localparam int max_len_c = 255;

endpackage

//--- hdl/burst_req_if.sv
interface burst_req_if
  import axi_burst_pkg::*;
#(
  parameter int addr_width_p = 32
) ();

  // handshake, transfer when both are high
  logic                    v;
  logic                    ready;

  // admitted burst fields
  logic [addr_width_p-1:0] addr;
  burst_e                  burst;
  logic [7:0]              len;
  logic [2:0]              size;

  // checker side offers legal bursts
  modport src (output v, addr, burst, len, size, input ready);

  // pump side takes them when idle
  modport dst (input v, addr, burst, len, size, output ready);

endinterface

//--- hdl/burst_cfg_regs.sv
module burst_cfg_regs
  import axi_burst_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       cfg_we_i,
  input  logic [2:0] cfg_allow_i,
  input  logic       reject_v_i,
  input  reject_e    reject_why_i,
  output logic [2:0] allow_o,
  output logic       err_o,
  output logic [7:0] err_count_o
);

  logic [2:0] allow_r;
  logic       err_r;
  logic [7:0] count_r;
  reject_e    last_why_r;

  // allow mask, one bit per burst type, all types allowed out of reset
  // a write lands at the next edge and steers requests after it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      allow_r <= 3'b111;
    end else if (cfg_we_i) begin
      allow_r <= cfg_allow_i;
    end
  end

  // reject strobe becomes a one cycle error pulse
  // counter sticks at 255
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_r   <= 1'b0;
      count_r <= '0;
    end else begin
      err_r <= reject_v_i;
      if (reject_v_i && (count_r != 8'hff)) begin
        count_r <= count_r + 8'd1;
      end
    end
  end

  // reason of the most recent reject, kept for checking only
  always_ff @(posedge clk_i) begin
    if (reject_v_i) begin
      last_why_r <= reject_why_i;
    end
  end

  assign allow_o     = allow_r;
  assign err_o       = err_r;
  assign err_count_o = count_r;

  // every error pulse must come from a real reject reason
  a_reject_has_reason : assert property (
    @(posedge clk_i) disable iff (reset_i) err_r |-> (last_why_r != e_ok)
  );

endmodule

//--- hdl/burst_admit_check.sv
module burst_admit_check
  import axi_burst_pkg::*;
#(
  parameter int addr_width_p = 32,
  parameter int data_width_p = 64
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_v_i,
  input  logic [addr_width_p-1:0] req_addr_i,
  input  burst_e                  req_burst_i,
  input  logic [7:0]              req_len_i,
  input  logic [2:0]              req_size_i,
  output logic                    req_ready_o,
  input  logic [2:0]              allow_i,
  output logic                    reject_v_o,
  output reject_e                 reject_why_o,
  burst_req_if.src                req
);

  localparam int lg_bytes_lp = $clog2(data_width_p/8);
  localparam int page_lg_lp  = $clog2(page_bytes_c);
  localparam int len_w_lp    = $clog2(max_len_c+1);

  logic                  allow_bit;
  logic                  wrap_len_ok;
  logic                  unaligned;
  logic                  crosses_page;
  logic [len_w_lp:0]     beats;
  logic [addr_width_p:0] span_bytes;
  logic [addr_width_p:0] last_byte;
  reject_e               why;

  // pick the allow bit of this burst type
  always_comb begin
    case (req_burst_i)
      e_fixed: allow_bit = allow_i[0];
      e_incr:  allow_bit = allow_i[1];
      e_wrap:  allow_bit = allow_i[2];
      default: allow_bit = 1'b0;
    endcase
  end

  // WRAP needs 2, 4, 8 or 16 beats and a size aligned start
  assign wrap_len_ok = req_len_i inside {8'd1, 8'd3, 8'd7, 8'd15};
  assign unaligned   = (req_addr_i & ~({addr_width_p{1'b1}} << req_size_i)) != '0;

  // last byte of an INCR burst, one extra bit so the top of memory also counts as a cross
  assign beats        = {1'b0, req_len_i} + 1'b1;
  assign span_bytes   = (addr_width_p+1)'(beats) << req_size_i;
  assign last_byte    = {1'b0, req_addr_i} + span_bytes - 1'b1;
  assign crosses_page = last_byte[addr_width_p:page_lg_lp]
                        != {1'b0, req_addr_i[addr_width_p-1:page_lg_lp]};

  // first failing rule wins
  always_comb begin
    if (req_burst_i == e_reserved) begin
      why = e_bad_type;
    end else if (!allow_bit) begin
      why = e_not_allowed;
    end else if (req_size_i > 3'(lg_bytes_lp)) begin
      why = e_bad_size;
    end else if ((req_burst_i == e_wrap) && (!wrap_len_ok || unaligned)) begin
      why = e_bad_wrap_len;
    end else if ((req_burst_i == e_incr) && crosses_page) begin
      why = e_cross_4k;
    end else begin
      why = e_ok;
    end
  end

  // ready always comes from the pump, so illegal requests are taken too
  assign req_ready_o = req.ready;

  // only legal bursts reach the pump
  assign req.v     = req_v_i && (why == e_ok);
  assign req.addr  = req_addr_i;
  assign req.burst = req_burst_i;
  assign req.len   = req_len_i;
  assign req.size  = req_size_i;

  // illegal requests are swallowed on the handshake
  assign reject_v_o   = req_v_i && req.ready && (why != e_ok);
  assign reject_why_o = why;

  a_admit_or_reject : assert property (
    @(posedge clk_i) disable iff (reset_i) !(req.v && reject_v_o)
  );

endmodule

//--- hdl/axi_burst_pump.sv
module axi_burst_pump
  import axi_burst_pkg::*;
#(
  parameter int addr_width_p = 32,
  parameter int data_width_p = 64
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  burst_req_if.dst                  req,
  output logic                      beat_v_o,
  input  logic                      beat_send_i,
  output logic [addr_width_p-1:0]   beat_addr_o,
  output logic [data_width_p/8-1:0] beat_mask_o,
  output logic [2:0]                beat_size_o,
  output logic                      beat_first_o,
  output logic                      beat_last_o
);

  localparam int bytes_lp    = data_width_p/8;
  localparam int lg_bytes_lp = $clog2(bytes_lp);
  localparam int page_lg_lp  = $clog2(page_bytes_c);
  localparam int len_w_lp    = $clog2(max_len_c+1);

  typedef enum logic {
    e_idle,
    e_send
  } state_e;

  state_e state_r, state_n;

  // captured burst
  logic [addr_width_p-1:0] start_r;
  burst_e                  burst_r;
  logic [len_w_lp-1:0]     len_r;
  logic [2:0]              size_r;

  // per beat state
  logic [len_w_lp-1:0]     count_r;
  logic [addr_width_p-1:0] addr_r;
  logic [addr_width_p-1:0] addr_n;

  logic                    accept;
  logic                    send;
  logic [addr_width_p-1:0] num_bytes;
  logic [addr_width_p-1:0] aligned_addr;
  logic [addr_width_p-1:0] incr_addr;
  logic                    is_aligned;
  logic [2:0]              lg_len;
  logic [addr_width_p-1:0] wrap_span;
  logic [addr_width_p-1:0] lower_wrap;
  logic [addr_width_p-1:0] upper_wrap;
  logic [lg_bytes_lp-1:0]  low_lane;
  logic [lg_bytes_lp-1:0]  high_lane;
  logic [lg_bytes_lp:0]    high_lane_p1;

  assign accept = req.v && req.ready;
  assign send   = beat_v_o && beat_send_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
      count_r <= '0;
    end else begin
      state_r <= state_n;
      // beat index restarts with each burst
      if (accept) begin
        count_r <= '0;
      end else if (send) begin
        count_r <= count_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      start_r <= req.addr;
      burst_r <= req.burst;
      len_r   <= req.len;
      size_r  <= req.size;
    end
    // beat 0 uses the raw start address
    if (accept) begin
      addr_r <= req.addr;
    end else if (send) begin
      addr_r <= addr_n;
    end
  end

  // idle until a legal burst arrives, then send until the last beat leaves
  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle: if (accept) state_n = e_send;
      e_send: if (send && beat_last_o) state_n = e_idle;
      default: state_n = e_idle;
    endcase
  end

  assign req.ready = (state_r == e_idle);
  assign beat_v_o  = (state_r == e_send);

  // INCR step from the size aligned address
  assign num_bytes    = addr_width_p'(1) << size_r;
  assign aligned_addr = (addr_r >> size_r) << size_r;
  assign incr_addr    = aligned_addr + num_bytes;
  assign is_aligned   = (aligned_addr == addr_r);

  // WRAP only allows len of 1, 3, 7 or 15, so log2 of the beat count is a lookup
  always_comb begin
    case (len_r)
      8'd1:    lg_len = 3'd1;
      8'd3:    lg_len = 3'd2;
      8'd7:    lg_len = 3'd3;
      8'd15:   lg_len = 3'd4;
      default: lg_len = 3'd0;
    endcase
  end

  // wrap window is (len+1) << size bytes, lower edge found by shifting only
  assign wrap_span  = (addr_width_p'(len_r) + 1'b1) << size_r;
  assign lower_wrap = ((start_r >> lg_len) >> size_r) << lg_len << size_r;
  assign upper_wrap = lower_wrap + wrap_span;

  always_comb begin
    case (burst_r)
      e_incr:  addr_n = incr_addr;
      e_wrap:  addr_n = (incr_addr == upper_wrap) ? lower_wrap : incr_addr;
      // FIXED and anything else repeats the address
      default: addr_n = addr_r;
    endcase
  end

  // byte lanes of this beat inside the data bus
  // unaligned beats end where the aligned transfer would end
  assign low_lane     = addr_r[lg_bytes_lp-1:0];
  assign high_lane    = is_aligned ? low_lane + num_bytes[lg_bytes_lp-1:0] - 1'b1
                                   : incr_addr[lg_bytes_lp-1:0] - 1'b1;
  assign high_lane_p1 = {1'b0, high_lane} + 1'b1;

  // ones from low lane up to and including high lane
  assign beat_mask_o = ({bytes_lp{1'b1}} << low_lane)
                       & ~({bytes_lp{1'b1}} << high_lane_p1);

  assign beat_addr_o  = addr_r;
  assign beat_size_o  = size_r;
  assign beat_first_o = (count_r == '0);
  assign beat_last_o  = (count_r == len_r);

  a_ready_xor_busy : assert property (
    @(posedge clk_i) disable iff (reset_i) !(req.ready && beat_v_o)
  );

  // a stalled beat keeps every field until it is sent
  a_hold_on_stall : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (beat_v_o && !beat_send_i) |=>
      (beat_v_o && $stable({beat_addr_o, beat_mask_o, beat_size_o,
                            beat_first_o, beat_last_o}))
  );

  // the checker keeps INCR bursts in one page, so no beat may leave it
  a_incr_in_page : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (beat_v_o && (burst_r == e_incr)) |->
      (beat_addr_o[addr_width_p-1:page_lg_lp] == start_r[addr_width_p-1:page_lg_lp])
  );

endmodule

//--- hdl/axi_burst_top.sv
module axi_burst_top
  import axi_burst_pkg::*;
#(
  parameter int addr_width_p = 32,
  parameter int data_width_p = 64
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  // request side
  input  logic                      req_v_i,
  output logic                      req_ready_o,
  input  logic [addr_width_p-1:0]   req_addr_i,
  input  burst_e                    req_burst_i,
  input  logic [7:0]                req_len_i,
  input  logic [2:0]                req_size_i,
  // beat side
  output logic                      beat_v_o,
  input  logic                      beat_send_i,
  output logic [addr_width_p-1:0]   beat_addr_o,
  output logic [data_width_p/8-1:0] beat_mask_o,
  output logic [2:0]                beat_size_o,
  output logic                      beat_first_o,
  output logic                      beat_last_o,
  // errors and config
  output logic                      err_o,
  output logic [7:0]                err_count_o,
  input  logic                      cfg_we_i,
  input  logic [2:0]                cfg_allow_i
);

  logic [2:0] allow;
  logic       reject_v;
  reject_e    reject_why;

  // admitted bursts from checker to pump
  burst_req_if #(.addr_width_p(addr_width_p)) req_if ();

  burst_cfg_regs cfg (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_allow_i (cfg_allow_i),
    .reject_v_i  (reject_v),
    .reject_why_i(reject_why),
    .allow_o     (allow),
    .err_o       (err_o),
    .err_count_o (err_count_o)
  );

  burst_admit_check #(
    .addr_width_p(addr_width_p),
    .data_width_p(data_width_p)
  ) check (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_v_i     (req_v_i),
    .req_addr_i  (req_addr_i),
    .req_burst_i (req_burst_i),
    .req_len_i   (req_len_i),
    .req_size_i  (req_size_i),
    .req_ready_o (req_ready_o),
    .allow_i     (allow),
    .reject_v_o  (reject_v),
    .reject_why_o(reject_why),
    .req         (req_if.src)
  );

  axi_burst_pump #(
    .addr_width_p(addr_width_p),
    .data_width_p(data_width_p)
  ) pump (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req         (req_if.dst),
    .beat_v_o    (beat_v_o),
    .beat_send_i (beat_send_i),
    .beat_addr_o (beat_addr_o),
    .beat_mask_o (beat_mask_o),
    .beat_size_o (beat_size_o),
    .beat_first_o(beat_first_o),
    .beat_last_o (beat_last_o)
  );

endmodule

//--- testbench/tb_beat_checker.sv
module tb_beat_checker
  import axi_burst_pkg::*;
#(
  parameter int addr_width_p = 32,
  parameter int data_width_p = 64
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      req_v_i,
  input  logic                      req_ready_i,
  input  logic [addr_width_p-1:0]   req_addr_i,
  input  burst_e                    req_burst_i,
  input  logic [7:0]                req_len_i,
  input  logic [2:0]                req_size_i,
  input  logic                      exp_reject_i,
  input  logic                      beat_v_i,
  input  logic                      beat_send_i,
  input  logic [addr_width_p-1:0]   beat_addr_i,
  input  logic [data_width_p/8-1:0] beat_mask_i,
  input  logic [2:0]                beat_size_i,
  input  logic                      beat_first_i,
  input  logic                      beat_last_i,
  input  logic                      err_i,
  input  logic [7:0]                err_count_i,
  output int                        tests_done_o,
  output int                        tests_failed_o,
  output int                        mismatches_o
);

  localparam int bytes_lp = data_width_p/8;

  // request under test
  logic [addr_width_p-1:0]   start;
  burst_e                    burst;
  logic [7:0]                len;
  logic [2:0]                size;
  logic                      reject;

  logic                      busy;
  logic                      ready_due;
  logic                      reject_due;
  logic                      stalled;
  logic                      test_bad;
  logic [7:0]                exp_count;
  logic [addr_width_p-1:0]   exp_addr;
  logic [addr_width_p+bytes_lp+4:0] held;
  int                        beat_k;
  int                        n_done = 0;
  int                        n_failed = 0;
  int                        n_mismatch = 0;

  // address of beat k from the FIXED, INCR and WRAP rules
  function automatic logic [addr_width_p-1:0] beat_address(input logic [addr_width_p-1:0] a,
      input burst_e b, input logic [7:0] n, input logic [2:0] sz, input int k);
    logic [addr_width_p-1:0] nb;
    logic [addr_width_p-1:0] aligned;
    logic [addr_width_p-1:0] span;
    logic [addr_width_p-1:0] lower;
    nb      = 1 << sz;
    aligned = a - (a % nb);
    span    = (n + 1) * nb;
    lower   = a - (a % span);
    if (k == 0 || b == e_fixed) begin
      return a;
    end
    if (b == e_wrap) begin
      return lower + ((aligned - lower + k * nb) % span);
    end
    return aligned + k * nb;
  endfunction

  // ones from the low lane to the high lane of this beat
  function automatic logic [bytes_lp-1:0] lane_mask(input logic [addr_width_p-1:0] a,
                                                    input logic [2:0] sz);
    logic [addr_width_p-1:0] nb;
    logic [addr_width_p-1:0] aligned;
    int                      low;
    int                      high;
    logic [bytes_lp-1:0]     m;
    nb      = 1 << sz;
    aligned = a - (a % nb);
    low     = a % bytes_lp;
    if (aligned == a) begin
      high = low + nb - 1;
    end else begin
      high = (aligned + nb - 1) % bytes_lp;
    end
    m = '0;
    for (int i = 0; i < bytes_lp; i++) begin
      if (i >= low && i <= high) begin
        m[i] = 1'b1;
      end
    end
    return m;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("FAIL %s expected 0x%0h actual 0x%0h in test %0d", name, exp, act, n_done);
      test_bad = 1'b1;
      n_mismatch++;
    end
  endtask

  task automatic report_problem(input string what);
    $display("test %0d went wrong: %s", n_done, what);
    test_bad = 1'b1;
    n_mismatch++;
  endtask

  // one line per table entry
  task automatic finish_test();
    $display("test %0d %s addr 0x%h len %0d size %0d %s: %s", n_done, burst.name(), start,
             len, size, reject ? "rejected" : "beats", test_bad ? "failed" : "ok");
    if (test_bad) begin
      n_failed++;
    end
    n_done++;
    test_bad = 1'b0;
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      busy       = 1'b0;
      ready_due  = 1'b0;
      reject_due = 1'b0;
      stalled    = 1'b0;
      test_bad   = 1'b0;
      exp_count  = '0;
      beat_k     = 0;
    end else begin
      // err pulse only in the cycle after a rejected request is taken
      check_value("err_o", 64'(reject_due), 64'(err_i));
      check_value("err_count_o", 64'(exp_count), 64'(err_count_i));
      if (reject_due) begin
        if (beat_v_i) begin
          report_problem("a rejected request produced a beat");
        end
        reject_due = 1'b0;
        finish_test();
      end
      // ready is back one cycle after the last send
      if (ready_due) begin
        check_value("req_ready_o", 64'(1), 64'(req_ready_i));
        ready_due = 1'b0;
        finish_test();
      end
      // a stalled beat must not move
      if (stalled) begin
        check_value("beat hold", 64'(held), 64'({beat_addr_i, beat_mask_i, beat_size_i,
                                                 beat_first_i, beat_last_i}));
      end
      if (beat_v_i && !busy) begin
        report_problem("beat_v_o high with no burst in progress");
      end else if (busy && !beat_v_i) begin
        report_problem($sformatf("beat_v_o dropped after %0d of %0d beats", beat_k, len + 1));
        busy = 1'b0;
        finish_test();
      end else if (busy) begin
        check_value("req_ready_o", 64'(0), 64'(req_ready_i));
        if (beat_send_i) begin
          exp_addr = beat_address(start, burst, len, size, beat_k);
          check_value("beat_addr_o", 64'(exp_addr), 64'(beat_addr_i));
          check_value("beat_mask_o", 64'(lane_mask(exp_addr, size)), 64'(beat_mask_i));
          check_value("beat_size_o", 64'(size), 64'(beat_size_i));
          check_value("beat_first_o", 64'(beat_k == 0), 64'(beat_first_i));
          check_value("beat_last_o", 64'(beat_k == int'(len)), 64'(beat_last_i));
          if (beat_k == int'(len)) begin
            busy      = 1'b0;
            ready_due = 1'b1;
          end
          beat_k++;
        end
      end
      stalled = beat_v_i && !beat_send_i;
      held    = {beat_addr_i, beat_mask_i, beat_size_i, beat_first_i, beat_last_i};
      // capture each request as it is taken
      if (req_v_i && req_ready_i) begin
        start  = req_addr_i;
        burst  = req_burst_i;
        len    = req_len_i;
        size   = req_size_i;
        reject = exp_reject_i;
        if (exp_reject_i) begin
          reject_due = 1'b1;
          // counter saturates at 255
          if (exp_count != 8'hff) begin
            exp_count = exp_count + 8'd1;
          end
        end else begin
          busy   = 1'b1;
          beat_k = 0;
        end
      end
    end
    tests_done_o   <= n_done;
    tests_failed_o <= n_failed;
    mismatches_o   <= n_mismatch;
  end

endmodule

//--- testbench/tb_axi_burst.sv
module tb_axi_burst
  import axi_burst_pkg::*;
();

  localparam int addr_width_lp = 32;
  localparam int data_width_lp = 64;

  // one row of the stimulus table, cfg write happens before the request
  typedef struct packed {
    logic [addr_width_lp-1:0] addr;
    burst_e                   burst;
    logic [7:0]               len;
    logic [2:0]               size;
    logic                     cfg_we;
    logic [2:0]               cfg_allow;
    logic                     reject;
  } entry_t;

  logic                       clk_i = 1'b0;
  logic                       reset_i = 1'b1;
  logic                       req_v_i = 1'b0;
  logic                       req_ready_o;
  logic [addr_width_lp-1:0]   req_addr_i = '0;
  burst_e                     req_burst_i = e_incr;
  logic [7:0]                 req_len_i = '0;
  logic [2:0]                 req_size_i = '0;
  logic                       beat_v_o;
  logic                       beat_send_i = 1'b0;
  logic [addr_width_lp-1:0]   beat_addr_o;
  logic [data_width_lp/8-1:0] beat_mask_o;
  logic [2:0]                 beat_size_o;
  logic                       beat_first_o;
  logic                       beat_last_o;
  logic                       err_o;
  logic [7:0]                 err_count_o;
  logic                       cfg_we_i = 1'b0;
  logic [2:0]                 cfg_allow_i = 3'b111;

  logic        exp_reject = 1'b0;
  logic [31:0] lfsr_q = 32'h9432_07ed;
  int          cycles = 0;
  int          cycle_limit = 0;
  int          tests_done;
  int          tests_failed;
  int          mismatches;
  entry_t      table_q[$];

  // x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic push_request(input logic [31:0] addr, input burst_e burst, input int len,
                              input int size, input logic cfg_we, input logic [2:0] cfg_allow,
                              input logic reject);
    table_q.push_back(entry_t'{addr, burst, 8'(len), 3'(size), cfg_we, cfg_allow, reject});
  endtask

  always #4 clk_i = ~clk_i;

  // back-pressure, send held off only when both fresh bits are zero
  always @(posedge clk_i) begin : send_gen
    logic b0;
    logic b1;
    lfsr_q = lfsr_step(lfsr_q);
    b0 = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    b1 = lfsr_q[0];
    beat_send_i <= b0 | b1;
  end

  // run limit from the table length
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout after %0d cycles with %0d of %0d tests finished",
               cycles, tests_done, table_q.size());
      $display("TB FAILED");
      $finish;
    end
  end

  axi_burst_top #(
    .addr_width_p(addr_width_lp),
    .data_width_p(data_width_lp)
  ) dut (.*);

  tb_beat_checker #(
    .addr_width_p(addr_width_lp),
    .data_width_p(data_width_lp)
  ) beat_check (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_v_i       (req_v_i),
    .req_ready_i   (req_ready_o),
    .req_addr_i    (req_addr_i),
    .req_burst_i   (req_burst_i),
    .req_len_i     (req_len_i),
    .req_size_i    (req_size_i),
    .exp_reject_i  (exp_reject),
    .beat_v_i      (beat_v_o),
    .beat_send_i   (beat_send_i),
    .beat_addr_i   (beat_addr_o),
    .beat_mask_i   (beat_mask_o),
    .beat_size_i   (beat_size_o),
    .beat_first_i  (beat_first_o),
    .beat_last_i   (beat_last_o),
    .err_i         (err_o),
    .err_count_i   (err_count_o),
    .tests_done_o  (tests_done),
    .tests_failed_o(tests_failed),
    .mismatches_o  (mismatches)
  );

  initial begin
    entry_t e;
    int     sum;
    // INCR, aligned and unaligned, sizes 0 to 3
    push_request(32'h1000, e_incr, 7, 3, 1'b0, 3'b111, 1'b0);
    push_request(32'h2006, e_incr, 5, 2, 1'b0, 3'b111, 1'b0);
    push_request(32'h3001, e_incr, 3, 1, 1'b0, 3'b111, 1'b0);
    push_request(32'h40fd, e_incr, 9, 0, 1'b0, 3'b111, 1'b0);
    push_request(32'h5003, e_incr, 15, 3, 1'b0, 3'b111, 1'b0);
    // WRAP of 2, 4, 8 and 16 beats starting mid block
    push_request(32'h6008, e_wrap, 1, 3, 1'b0, 3'b111, 1'b0);
    push_request(32'h7138, e_wrap, 3, 2, 1'b0, 3'b111, 1'b0);
    push_request(32'h8020, e_wrap, 7, 3, 1'b0, 3'b111, 1'b0);
    push_request(32'h901a, e_wrap, 15, 1, 1'b0, 3'b111, 1'b0);
    // FIXED repeats address and mask
    push_request(32'ha006, e_fixed, 3, 2, 1'b0, 3'b111, 1'b0);
    push_request(32'ha013, e_fixed, 4, 0, 1'b0, 3'b111, 1'b0);
    // long burst, lots of stalls
    push_request(32'hb000, e_incr, 255, 3, 1'b0, 3'b111, 1'b0);
    // illegal: reserved, oversize, wrap length, wrap unaligned, 4 KB cross
    push_request(32'hc000, e_reserved, 0, 0, 1'b0, 3'b111, 1'b1);
    push_request(32'hc100, e_incr, 1, 4, 1'b0, 3'b111, 1'b1);
    push_request(32'hc200, e_wrap, 2, 2, 1'b0, 3'b111, 1'b1);
    push_request(32'hc202, e_wrap, 3, 2, 1'b0, 3'b111, 1'b1);
    push_request(32'hcff8, e_incr, 1, 3, 1'b0, 3'b111, 1'b1);
    // WRAP masked off, then allowed again
    push_request(32'hd010, e_wrap, 3, 3, 1'b1, 3'b011, 1'b1);
    push_request(32'hd010, e_wrap, 3, 3, 1'b1, 3'b111, 1'b0);
    // single beat, and a burst ending right at the page edge
    push_request(32'he00c, e_incr, 0, 2, 1'b0, 3'b111, 1'b0);
    push_request(32'heff0, e_incr, 1, 3, 1'b0, 3'b111, 1'b0);

    sum = 0;
    foreach (table_q[i]) begin
      sum += int'(table_q[i].len) + 2;
    end
    cycle_limit = 4 * sum + 200;

    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;

    foreach (table_q[i]) begin
      e = table_q[i];
      if (e.cfg_we) begin
        cfg_we_i    <= 1'b1;
        cfg_allow_i <= e.cfg_allow;
        @(posedge clk_i);
        cfg_we_i <= 1'b0;
      end
      req_v_i     <= 1'b1;
      req_addr_i  <= e.addr;
      req_burst_i <= e.burst;
      req_len_i   <= e.len;
      req_size_i  <= e.size;
      exp_reject  <= e.reject;
      // hold the request until it is taken
      @(posedge clk_i);
      while (!req_ready_o) begin
        @(posedge clk_i);
      end
      req_v_i <= 1'b0;
      while (tests_done < i + 1) begin
        @(posedge clk_i);
      end
    end

    // a few idle cycles to catch stray beats or error pulses
    repeat (3) @(posedge clk_i);
    $display("tests %0d, passed %0d, failed %0d, mismatches %0d",
             tests_done, tests_done - tests_failed, tests_failed, mismatches);
    if (tests_failed == 0 && mismatches == 0 && tests_done == table_q.size()) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
hdl/axi_burst_pkg.sv
hdl/burst_req_if.sv
hdl/burst_cfg_regs.sv
hdl/burst_admit_check.sv
hdl/axi_burst_pump.sv
hdl/axi_burst_top.sv
testbench/tb_beat_checker.sv
testbench/tb_axi_burst.sv

//--- Makefile
SIM  := obj_dir/Vtb_axi_burst
SRCS := $(wildcard hdl/*.sv testbench/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_burst -f sim.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" sim.log || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf obj_dir sim.log
